// File: compile.f
+incdir+source
source/arith_pkg.sv
source/div_core.sv
source/mul_core.sv
source/arith_engine.sv
source/result_fifo.sv
source/result_port.sv
source/arith_top.sv
testbench/arith_properties.sv
testbench/tb_arith_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_arith_top
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# Pass only when the log holds the pass line
run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/tb_arith_top.sv
`timescale 1ns/1ps

`include "arith_macros.svh"

module tb_arith_top import arith_pkg::*; ();

    localparam int MAX_CYCLES = 20000;
    localparam int CAPACITY   = (1 << `ARITH_FIFO_AW) + 1;   // FIFO plus port register
    localparam int READY_WAIT = 80;
    localparam int N_RAND     = 100;

    logic          clk;
    logic          rst;
    logic          start;
    arith_cmd_t    cmd;
    logic          cmd_ready;
    arith_result_t result;
    logic          avail;
    logic          read;

    logic [31:0] seed   = 32'h2c62_f6b6;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    arith_top i_arith_top (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .result    (result),
        .avail     (avail),
        .read      (read)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_word();
        seed = xorshift32(seed);
        return seed;
    endfunction

    // Reference model, signed quotient truncates toward zero
    function automatic logic [31:0] expected_value(input arith_op_e op, input logic [31:0] a,
                                                   input logic [31:0] b);
        logic [63:0] prod;
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        logic [31:0] mag_q;
        logic        neg;
        prod  = {32'd0, a} * {32'd0, b};
        mag_a = (op == OP_DIVS && a[31]) ? -a : a;
        mag_b = (op == OP_DIVS && b[31]) ? -b : b;
        neg   = (op == OP_DIVS) && (a[31] != b[31]);
        mag_q = (mag_b == 32'd0) ? 32'hffff_ffff : mag_a / mag_b;
        if (op == OP_MULU) return prod[31:0];
        return neg ? -mag_q : mag_q;
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic wait_ready(input int limit, output logic seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge clk);
            seen = cmd_ready;
            n++;
        end
    endtask

    task automatic issue_cmd(input arith_op_e op, input logic [31:0] a, input logic [31:0] b);
        start <= 1'b1;
        cmd   <= '{op: op, a: a, b: b};
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic take_result(output arith_result_t r);
        do begin
            @(posedge clk);
        end while (!avail);
        r = result;
        read <= 1'b1;
        @(posedge clk);
        read <= 1'b0;
    endtask

    task automatic run_op(input arith_op_e op, input logic [31:0] a, input logic [31:0] b);
        logic          seen;
        arith_result_t r;
        wait_ready(READY_WAIT, seen);
        if (!seen) begin
            errors++;
            $display("cmd_ready never rose before %s at %0t ns", op.name(), $time);
        end else begin
            issue_cmd(op, a, b);
            take_result(r);
            check($sformatf("%s tag", op.name()), r.op, op);
            check($sformatf("%s %h, %h", op.name(), a, b), r.value, expected_value(op, a, b));
        end
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    // ================================================
    // Tests
    // ================================================
    task automatic test_reset();
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        @(posedge clk);
        check("cmd_ready after reset", cmd_ready, 1'b1);
        check("avail after reset", avail, 1'b0);
        report_test("reset", c0, e0);
    endtask

    task automatic test_mulu();
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        run_op(OP_MULU, 32'd0, 32'hdead_beef);
        run_op(OP_MULU, 32'd1, 32'hdead_beef);
        run_op(OP_MULU, 32'hffff_ffff, 32'hffff_ffff);
        run_op(OP_MULU, 32'h0001_0000, 32'h0001_0000);   // Product above 32 bits only
        run_op(OP_MULU, 32'h0000_ffff, 32'h0000_ffff);
        run_op(OP_MULU, 32'h1234_5678, 32'h9abc_def0);
        for (int i = 0; i < N_RAND; i++) begin
            run_op(OP_MULU, next_word(), next_word());
        end
        report_test("multiply unsigned", c0, e0);
    endtask

    task automatic test_divu();
        logic [31:0] a;
        logic [31:0] b;
        int          c0;
        int          e0;
        c0 = checks;
        e0 = errors;
        run_op(OP_DIVU, 32'd12345, 32'd0);
        run_op(OP_DIVU, 32'd0, 32'd0);
        run_op(OP_DIVU, 32'd5, 32'd7);
        run_op(OP_DIVU, 32'hffff_ffff, 32'd1);
        run_op(OP_DIVU, 32'hffff_ffff, 32'hffff_ffff);
        for (int i = 0; i < N_RAND; i++) begin
            a = next_word();
            b = next_word() >> next_word() % 32;   // Spread of quotient sizes
            run_op(OP_DIVU, a, b);
        end
        report_test("divide unsigned", c0, e0);
    endtask

    task automatic test_divs();
        logic [31:0] a;
        logic [31:0] b;
        int          c0;
        int          e0;
        c0 = checks;
        e0 = errors;
        run_op(OP_DIVS, 32'd100, 32'd7);
        run_op(OP_DIVS, -32'd100, 32'd7);
        run_op(OP_DIVS, 32'd100, -32'd7);
        run_op(OP_DIVS, -32'd100, -32'd7);
        run_op(OP_DIVS, -32'd7, 32'd2);
        run_op(OP_DIVS, 32'h8000_0000, -32'd1);
        run_op(OP_DIVS, 32'h8000_0000, 32'd2);
        run_op(OP_DIVS, 32'h8000_0000, 32'h8000_0000);
        run_op(OP_DIVS, 32'd5, 32'd0);
        run_op(OP_DIVS, -32'd5, 32'd0);
        for (int i = 0; i < N_RAND; i++) begin
            a = next_word();
            b = $signed(next_word()) >>> (next_word() % 32);
            run_op(OP_DIVS, a, b);
        end
        report_test("divide signed", c0, e0);
    endtask

    task automatic test_backpressure();
        arith_op_e     rot[3] = '{OP_MULU, OP_DIVU, OP_DIVS};
        arith_op_e     op_q[$];
        logic [31:0]   exp_q[$];
        arith_op_e     op;
        arith_result_t r;
        logic [31:0]   a;
        logic [31:0]   b;
        logic          seen;
        int            c0;
        int            e0;
        c0   = checks;
        e0   = errors;
        seen = 1'b1;
        while (seen && op_q.size() < 2 * CAPACITY) begin
            wait_ready(READY_WAIT, seen);
            if (seen) begin
                op = rot[op_q.size() % 3];
                a  = next_word();
                b  = next_word() >> 8;
                issue_cmd(op, a, b);
                op_q.push_back(op);
                exp_q.push_back(expected_value(op, a, b));
            end
        end
        check("commands accepted without reads", op_q.size(), CAPACITY);
        check("avail while stalled", avail, 1'b1);
        while (op_q.size() > 0) begin
            take_result(r);
            check("queued tag", r.op, op_q.pop_front());
            check("queued value", r.value, exp_q.pop_front());
        end
        report_test("backpressure", c0, e0);
    endtask

    initial begin
        rst   <= 1'b1;
        start <= 1'b0;
        read  <= 1'b0;
        cmd   <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_mulu();
        test_divu();
        test_divs();
        test_backpressure();
        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/arith_properties.sv
`timescale 1ns/1ps

`include "arith_macros.svh"

module arith_properties import arith_pkg::*; (
    input logic                    clk,
    input logic                    rst,
    input logic                    push,
    input logic                    fifo_full,
    input logic                    pop,
    input logic                    fifo_empty,
    input logic [`ARITH_FIFO_AW:0] fifo_count,
    input logic                    avail,
    input logic                    read
);

    localparam int DEPTH = 1 << `ARITH_FIFO_AW;

    // ================================================
    // Result FIFO
    // ================================================
    count_in_range: assert property (@(posedge clk) disable iff (rst) fifo_count <= DEPTH)
        else $error("FIFO count %0d above depth", fifo_count);

    no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && fifo_full))
        else $error("push while FIFO full");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) !(pop && fifo_empty))
        else $error("pop while FIFO empty");

    // Shown result stays until the host reads it
    avail_held: assert property (@(posedge clk) disable iff (rst) avail && !read |=> avail)
        else $error("avail dropped without read");

endmodule

bind arith_top arith_properties i_arith_properties (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .fifo_full  (fifo_full),
    .pop        (pop),
    .fifo_empty (fifo_empty),
    .fifo_count (i_result_fifo.count),
    .avail      (avail),
    .read       (read)
);

// File: source/arith_top.sv
`timescale 1ns/1ps

`include "arith_macros.svh"

module arith_top import arith_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  arith_cmd_t    cmd,
    output logic          cmd_ready,
    output arith_result_t result,
    output logic          avail,
    input  logic          read
);

    logic          push;
    arith_result_t push_data;
    logic          fifo_full;
    logic          fifo_empty;
    logic          pop;
    arith_result_t pop_data;

    // ================================================
    // Producer, buffer, consumer
    // ================================================
    arith_engine i_arith_engine (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cmd       (cmd),
        .fifo_full (fifo_full),
        .cmd_ready (cmd_ready),
        .push      (push),
        .push_data (push_data)
    );

    result_fifo #(.AW(`ARITH_FIFO_AW)) i_result_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    result_port i_result_port (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .fifo_data  (pop_data),
        .pop        (pop),
        .result     (result),
        .avail      (avail),
        .read       (read)
    );

endmodule

// File: source/result_port.sv
`timescale 1ns/1ps

module result_port import arith_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          fifo_empty,
    input  arith_result_t fifo_data,
    output logic          pop,
    output arith_result_t result,
    output logic          avail,
    input  logic          read
);

    logic pending;   // Pop issued, data arrives next cycle
    logic holding;

    assign pop = !holding && !pending && !fifo_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            holding <= 1'b0;
        end else begin
            pending <= pop;
            if (pending) begin
                holding <= 1'b1;
            end else if (read) begin
                holding <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pending) result <= fifo_data;
    end

    assign avail = holding;

endmodule

// File: source/result_fifo.sv
`timescale 1ns/1ps

`include "arith_macros.svh"

module result_fifo import arith_pkg::*; #(
    parameter int AW = `ARITH_FIFO_AW
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  arith_result_t push_data,
    input  logic          pop,
    output arith_result_t pop_data,
    output logic          full,
    output logic          empty
);

    localparam int DEPTH = 1 << AW;

    arith_result_t mem [DEPTH];
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] wr_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
        if (do_pop) pop_data <= mem[rd_ptr];   // Registered read
    end

    assign full  = count == (AW + 1)'(DEPTH);
    assign empty = count == '0;

endmodule

// File: source/arith_engine.sv
`timescale 1ns/1ps

module arith_engine import arith_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  arith_cmd_t    cmd,
    input  logic          fifo_full,
    output logic          cmd_ready,
    output logic          push,
    output arith_result_t push_data
);

    engine_state_e state;
    arith_op_e     op_q;
    logic          accept;
    logic          is_mul;
    logic          mul_go;
    logic          div_go;
    logic          mul_done;
    logic          div_done;
    logic          core_done;
    arith_word_t   product;
    arith_word_t   quotient;

    assign cmd_ready = (state == ST_IDLE) && !fifo_full;
    assign accept    = start && cmd_ready;
    assign is_mul    = cmd.op == OP_MULU;
    assign mul_go    = accept && is_mul;
    assign div_go    = accept && !is_mul;
    assign core_done = (op_q == OP_MULU) ? mul_done : div_done;

    // ================================================
    // Sequencing
    // ================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (accept) state <= ST_RUN;
                ST_RUN:  if (core_done) state <= ST_PUSH;
                ST_PUSH: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) op_q <= cmd.op;   // Tag for the result
    end

    div_core i_div_core (
        .clk       (clk),
        .rst       (rst),
        .go        (div_go),
        .is_signed (cmd.op == OP_DIVS),
        .dividend  (cmd.a),
        .divisor   (cmd.b),
        .quotient  (quotient),
        .done      (div_done)
    );

    mul_core i_mul_core (
        .clk     (clk),
        .rst     (rst),
        .go      (mul_go),
        .a       (cmd.a),
        .b       (cmd.b),
        .product (product),
        .done    (mul_done)
    );

    assign push            = state == ST_PUSH;
    assign push_data.op    = op_q;
    assign push_data.value = (op_q == OP_MULU) ? product : quotient;

endmodule

// File: source/mul_core.sv
`timescale 1ns/1ps

`include "arith_macros.svh"

module mul_core import arith_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        go,
    input  arith_word_t a,
    input  arith_word_t b,
    output arith_word_t product,
    output logic        done
);

    localparam int W      = `ARITH_DATA_W;
    localparam int DW     = `ARITH_DIGIT_W;
    localparam int DIGITS = W / DW;
    localparam int PW     = $clog2(2 * DIGITS);

    arith_word_t a_q;
    arith_word_t b_q;
    arith_word_t acc;
    arith_word_t a_rot;
    arith_word_t b_rot;
    arith_word_t digit_prod;
    arith_word_t shifted;
    logic [PW-1:0] apos;
    logic [PW-1:0] bpos;
    logic [PW-1:0] dest;   // Digit position of the current partial product

    // Rotate right by one digit so the next digit sits at the bottom
    assign a_rot = (a_q >> DW) | (a_q << (W - DW));
    assign b_rot = (b_q >> DW) | (b_q << (W - DW));

    assign digit_prod = W'(a_q[DW-1:0]) * W'(b_q[DW-1:0]);
    assign shifted    = digit_prod << (dest * DW);   // Upper positions fall off

    always_ff @(posedge clk) begin
        if (rst) begin
            apos <= '0;
            bpos <= PW'(DIGITS);
            dest <= '0;
        end else if (go) begin
            apos <= '0;
            bpos <= '0;
            dest <= '0;
        end else if (!done) begin
            if (apos == PW'(DIGITS - 1)) begin
                apos <= '0;
                bpos <= bpos + 1'b1;
                dest <= bpos + 1'b1;   // Next row starts at the b digit position
            end else begin
                apos <= apos + 1'b1;
                dest <= dest + 1'b1;
            end
        end
    end

    // Operands and accumulator
    always_ff @(posedge clk) begin
        if (go) begin
            a_q <= a;
            b_q <= b;
            acc <= '0;
        end else if (!done) begin
            a_q <= a_rot;
            if (apos == PW'(DIGITS - 1)) begin
                b_q <= b_rot;
            end
            acc <= acc + shifted;
        end
    end

    assign done    = bpos == PW'(DIGITS);
    assign product = acc;

endmodule

// File: source/div_core.sv
`timescale 1ns/1ps

`include "arith_macros.svh"

module div_core import arith_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        go,
    input  logic        is_signed,
    input  arith_word_t dividend,
    input  arith_word_t divisor,
    output arith_word_t quotient,
    output logic        done
);

    localparam int W  = `ARITH_DATA_W;
    localparam int CW = $clog2(W + 1);

    logic [CW-1:0]  count;
    logic [2*W-1:0] acc;       // Remainder on top, quotient bits shift in below
    arith_word_t    mag_b;
    logic           negate;
    logic [W+1:0]   diff;

    // Shifted partial remainder minus divisor, MSB is the borrow
    assign diff = {1'b0, acc[2*W-1:W-1]} - {2'b00, mag_b};

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (go) begin
            count <= CW'(W);
        end else if (!done) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            acc <= '0;
            if (is_signed && dividend[W-1]) begin
                acc[W-1:0] <= -dividend;
            end else begin
                acc[W-1:0] <= dividend;
            end
            if (is_signed && divisor[W-1]) begin
                mag_b <= -divisor;
            end else begin
                mag_b <= divisor;
            end
            negate <= is_signed && (dividend[W-1] ^ divisor[W-1]);
        end else if (!done) begin
            if (diff[W+1]) begin
                acc <= {acc[2*W-2:0], 1'b0};
            end else begin
                acc <= {diff[W-1:0], acc[W-2:0], 1'b1};
            end
        end
    end

    // Zero divisor never borrows, so the magnitude ends up all ones
    assign done     = count == '0;
    assign quotient = negate ? -acc[W-1:0] : acc[W-1:0];

endmodule

// File: source/arith_pkg.sv
package arith_pkg;

    `include "arith_macros.svh"

    typedef logic [`ARITH_DATA_W-1:0] arith_word_t;

    // Opcodes
    typedef enum logic [1:0] {
        OP_MULU = 2'd0,  // Low half of unsigned product
        OP_DIVU = 2'd1,
        OP_DIVS = 2'd2   // Quotient truncated toward zero
    } arith_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_PUSH = 2'd2
    } engine_state_e;

    typedef struct packed {
        arith_op_e   op;
        arith_word_t a;
        arith_word_t b;
    } arith_cmd_t;

    // Tagged result as stored in the FIFO
    typedef struct packed {
        arith_op_e   op;
        arith_word_t value;
    } arith_result_t;

endpackage

// File: source/arith_macros.svh
`ifndef ARITH_MACROS_SVH
`define ARITH_MACROS_SVH

// ================================================
// Datapath sizes
// ================================================

`define ARITH_DATA_W  32   // Operand and result width
`define ARITH_DIGIT_W 16   // Multiplier digit, must divide data width

// FIFO depth is 2**AW
`define ARITH_FIFO_AW 2

`endif
